//--- clock_pkg.sv
`default_nettype none

package clock_pkg;

  localparam int bcd_digit_w = 4;

  // one two-digit BCD field, tens in the upper nibble
  typedef logic [2*bcd_digit_w-1:0] bcd2_t;

  // highest tens digit allowed while keying in a value
  localparam logic [bcd_digit_w-1:0] sec_tens_max  = 4'd5;
  localparam logic [bcd_digit_w-1:0] min_tens_max  = 4'd5;
  localparam logic [bcd_digit_w-1:0] hour_tens_max = 4'd2;
  localparam logic [bcd_digit_w-1:0] units_max     = 4'd9;

  localparam bcd2_t sec_last  = 8'h59;
  localparam bcd2_t min_last  = 8'h59;
  localparam bcd2_t hour_last = 8'h23;
  localparam bcd2_t noon_hour = 8'h12;

  typedef struct packed {
    bcd2_t hour;  // bits 23:16
    bcd2_t min;
    bcd2_t sec;
  } bcd_time_t;

  typedef enum logic [1:0] {
    mode_run       = 2'd0,
    mode_set_time  = 2'd1,
    mode_set_alarm = 2'd2,
    mode_set_timer = 2'd3
  } clock_mode_e;

  typedef enum logic [1:0] {
    field_hour = 2'd0,
    field_min  = 2'd1,
    field_sec  = 2'd2
  } set_field_e;

  // next BCD value, back to 00 once last is reached
  function automatic bcd2_t bcd_inc(input bcd2_t value, input bcd2_t last);
    bcd2_t result;
    if (value == last) begin
      result = '0;
    end else if (value[bcd_digit_w-1:0] == units_max) begin
      result = {value[2*bcd_digit_w-1:bcd_digit_w] + 1'b1, {bcd_digit_w{1'b0}}};  // carry
    end else begin
      result = value + 1'b1;
    end
    return result;
  endfunction

  // previous BCD value, 00 wraps round to last
  function automatic bcd2_t bcd_dec(input bcd2_t value, input bcd2_t last);
    bcd2_t result;
    if (value == '0) begin
      result = last;
    end else if (value[bcd_digit_w-1:0] == '0) begin
      result = {value[2*bcd_digit_w-1:bcd_digit_w] - 1'b1, units_max};  // borrow
    end else begin
      result = value - 1'b1;
    end
    return result;
  endfunction

endpackage

`default_nettype wire

//--- time_setter.sv
`timescale 1ns/1ps
`default_nettype none

module time_setter (
  input  logic                   clk,
  input  logic                   rst,
  input  clock_pkg::clock_mode_e mode,
  input  logic                   button_tens,
  input  logic                   button_units,
  input  logic                   button_next,
  output clock_pkg::bcd_time_t   entry_time,
  output logic                   entry_active
);

  import clock_pkg::*;

  set_field_e                 field;
  logic                       active_q;  // entry_active one cycle late
  logic                       entry_start;
  bcd2_t                      cur_field;
  bcd2_t                      next_field;
  logic [bcd_digit_w-1:0]     tens_limit;

  assign entry_active = (mode != mode_run);
  assign entry_start  = entry_active && !active_q;

  // digit stepping on the field under edit
  always_comb begin
    case (field)
      field_min: begin
        cur_field  = entry_time.min;
        tens_limit = min_tens_max;
      end
      field_sec: begin
        cur_field  = entry_time.sec;
        tens_limit = sec_tens_max;
      end
      default: begin
        cur_field  = entry_time.hour;
        tens_limit = hour_tens_max;
      end
    endcase

    next_field = cur_field;
    if (button_tens) begin
      next_field[2*bcd_digit_w-1:bcd_digit_w] =
        (cur_field[2*bcd_digit_w-1:bcd_digit_w] >= tens_limit) ?
        '0 : cur_field[2*bcd_digit_w-1:bcd_digit_w] + 1'b1;
    end
    if (button_units) begin
      next_field[bcd_digit_w-1:0] =
        (cur_field[bcd_digit_w-1:0] >= units_max) ? '0 : cur_field[bcd_digit_w-1:0] + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q   <= 1'b0;
      field      <= field_hour;
      entry_time <= '0;
    end else begin
      active_q <= entry_active;
      if (entry_start) begin
        // fresh entry, start from 00:00:00 on the hour field
        field      <= field_hour;
        entry_time <= '0;
      end else if (entry_active) begin
        case (field)
          field_min: entry_time.min  <= next_field;
          field_sec: entry_time.sec  <= next_field;
          default:   entry_time.hour <= next_field;
        endcase

        if (button_next) begin
          case (field)
            field_hour: field <= field_min;
            field_min:  field <= field_sec;
            default:    field <= field_hour;
          endcase
        end
      end
    end
  end

  a_field_legal: assert property (@(posedge clk) disable iff (rst)
    field inside {field_hour, field_min, field_sec})
    else $error("time_setter: field state left the legal set");

endmodule

`default_nettype wire

//--- time_counter.sv
`timescale 1ns/1ps
`default_nettype none

module time_counter (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   tick,
  input  clock_pkg::clock_mode_e mode,
  input  clock_pkg::bcd_time_t   entry_time,
  output clock_pkg::bcd_time_t   clock_time
);

  import clock_pkg::*;

  logic sec_wrap;
  logic min_wrap;

  assign sec_wrap = (clock_time.sec == sec_last);
  assign min_wrap = sec_wrap && (clock_time.min == min_last);

  always_ff @(posedge clk) begin
    if (rst) begin
      clock_time <= '0;
    end else if (mode == mode_set_time) begin
      clock_time <= entry_time;  // follows the entry while setting
    end else if (mode == mode_run && tick) begin
      clock_time.sec <= bcd_inc(clock_time.sec, sec_last);
      if (sec_wrap) begin
        clock_time.min <= bcd_inc(clock_time.min, min_last);
      end
      // 23:59:59 rolls over to midnight
      if (min_wrap) begin
        clock_time.hour <= bcd_inc(clock_time.hour, hour_last);
      end
    end
  end

  a_sec_range: assert property (@(posedge clk) disable iff (rst)
    (mode == mode_run) |-> (clock_time.sec <= sec_last))
    else $error("time_counter: seconds out of range while running");

endmodule

`default_nettype wire

//--- countdown_timer.sv
`timescale 1ns/1ps
`default_nettype none

module countdown_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   tick,
  input  clock_pkg::clock_mode_e mode,
  input  clock_pkg::bcd_time_t   entry_time,
  output clock_pkg::bcd_time_t   timer_time,
  output logic                   timer_buzzer
);

  import clock_pkg::*;

  logic timer_zero;
  logic sec_borrow;
  logic min_borrow;

  assign timer_zero = (timer_time == '0);
  assign sec_borrow = (timer_time.sec == '0);
  assign min_borrow = sec_borrow && (timer_time.min == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      timer_time   <= '0;
      timer_buzzer <= 1'b0;
    end else if (mode == mode_set_timer) begin
      timer_time   <= entry_time;
      timer_buzzer <= 1'b0;  // reload silences the buzzer
    end else if (tick && !timer_buzzer) begin
      if (timer_zero) begin
        timer_buzzer <= 1'b1;  // latched until the next reload
      end else begin
        timer_time.sec <= bcd_dec(timer_time.sec, sec_last);
        if (sec_borrow) begin
          timer_time.min <= bcd_dec(timer_time.min, min_last);
        end
        if (min_borrow) begin
          timer_time.hour <= bcd_dec(timer_time.hour, hour_last);
        end
      end
    end
  end

  a_buzzer_at_zero: assert property (@(posedge clk) disable iff (rst)
    timer_buzzer |-> timer_zero)
    else $error("countdown_timer: buzzer high with time left");

endmodule

`default_nettype wire

//--- alarm_matcher.sv
`timescale 1ns/1ps
`default_nettype none

module alarm_matcher (
  input  logic                   clk,
  input  logic                   rst,
  input  clock_pkg::clock_mode_e mode,
  input  clock_pkg::bcd_time_t   entry_time,
  input  clock_pkg::bcd_time_t   clock_time,
  output clock_pkg::bcd_time_t   alarm_time,
  output logic                   alarm_ring
);

  import clock_pkg::*;

  bcd2_t alarm_hour;
  bcd2_t alarm_min;
  logic  armed;
  logic  match;

  // seconds play no part in the alarm
  assign alarm_time = {alarm_hour, alarm_min, 8'h00};
  assign match      = (clock_time.hour == alarm_hour) && (clock_time.min == alarm_min);

  always_ff @(posedge clk) begin
    if (rst) begin
      alarm_hour <= '0;
      alarm_min  <= '0;
      armed      <= 1'b0;
      alarm_ring <= 1'b0;
    end else begin
      if (mode == mode_set_alarm) begin
        alarm_hour <= entry_time.hour;
        alarm_min  <= entry_time.min;
        armed      <= 1'b1;
      end
      alarm_ring <= armed && match;  // stays up for the whole matching minute
    end
  end

endmodule

`default_nettype wire

//--- display_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module display_formatter (
  input  clock_pkg::clock_mode_e mode,
  input  logic                   twelve_hour,
  input  clock_pkg::bcd_time_t   clock_time,
  input  clock_pkg::bcd_time_t   alarm_time,
  input  clock_pkg::bcd_time_t   timer_time,
  output clock_pkg::bcd_time_t   display_time,
  output logic                   pm
);

  import clock_pkg::*;

  bcd_time_t              shown;
  bcd2_t                  hour_12;
  logic [bcd_digit_w-1:0] hour_units;
  logic                   use_12h;

  assign use_12h    = (mode == mode_run) && twelve_hour;
  assign hour_units = shown.hour[bcd_digit_w-1:0];

  always_comb begin
    case (mode)
      mode_set_alarm: shown = alarm_time;
      mode_set_timer: shown = timer_time;
      default:        shown = clock_time;
    endcase
  end

  // 24h to 12h hour, digit by digit
  always_comb begin
    hour_12 = shown.hour;
    if (shown.hour == '0) begin
      hour_12 = noon_hour;  // midnight shows as 12
    end else if (shown.hour > noon_hour) begin
      if (shown.hour[2*bcd_digit_w-1:bcd_digit_w] == 4'd1) begin
        hour_12 = {4'd0, hour_units - 4'd2};  // 13..19
      end else if (hour_units < 4'd2) begin
        hour_12 = {4'd0, hour_units + 4'd8};  // 20, 21
      end else begin
        hour_12 = {4'd1, hour_units - 4'd2};  // 22, 23
      end
    end
  end

  assign display_time = use_12h ? {hour_12, shown.min, shown.sec} : shown;
  assign pm           = use_12h && (shown.hour >= noon_hour);

endmodule

`default_nettype wire

//--- clock_top.sv
`timescale 1ns/1ps
`default_nettype none

module clock_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   tick,
  input  clock_pkg::clock_mode_e mode,
  input  logic                   button_tens,
  input  logic                   button_units,
  input  logic                   button_next,
  input  logic                   twelve_hour,
  output clock_pkg::bcd_time_t   display_time,
  output logic                   pm,
  output logic                   alarm_ring,
  output logic                   timer_buzzer
);

  import clock_pkg::*;

  bcd_time_t entry_time;
  bcd_time_t clock_time;
  bcd_time_t alarm_time;
  bcd_time_t timer_time;

  // each block below decodes mode on its own
  time_setter time_setter_inst (
    .clk          (clk),
    .rst          (rst),
    .mode         (mode),
    .button_tens  (button_tens),
    .button_units (button_units),
    .button_next  (button_next),
    .entry_time   (entry_time),
    .entry_active ()
  );

  time_counter time_counter_inst (
    .clk        (clk),
    .rst        (rst),
    .tick       (tick),
    .mode       (mode),
    .entry_time (entry_time),
    .clock_time (clock_time)
  );

  countdown_timer countdown_timer_inst (
    .clk          (clk),
    .rst          (rst),
    .tick         (tick),
    .mode         (mode),
    .entry_time   (entry_time),
    .timer_time   (timer_time),
    .timer_buzzer (timer_buzzer)
  );

  alarm_matcher alarm_matcher_inst (
    .clk        (clk),
    .rst        (rst),
    .mode       (mode),
    .entry_time (entry_time),
    .clock_time (clock_time),
    .alarm_time (alarm_time),
    .alarm_ring (alarm_ring)
  );

  display_formatter display_formatter_inst (
    .mode         (mode),
    .twelve_hour  (twelve_hour),
    .clock_time   (clock_time),
    .alarm_time   (alarm_time),
    .timer_time   (timer_time),
    .display_time (display_time),
    .pm           (pm)
  );

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock;

  import clock_pkg::*;

  localparam int max_cycles = 5000;  // watchdog budget
  localparam int ring_limit = 8;

  logic        clk;
  logic        rst;
  logic        tick;
  clock_mode_e mode;
  logic        button_tens;
  logic        button_units;
  logic        button_next;
  logic        twelve_hour;
  bcd_time_t   display_time;
  logic        pm;
  logic        alarm_ring;
  logic        timer_buzzer;

  int error_count;
  int test_errors;
  int test_count;

  clock_top clock_top_inst (
    .clk          (clk),
    .rst          (rst),
    .tick         (tick),
    .mode         (mode),
    .button_tens  (button_tens),
    .button_units (button_units),
    .button_next  (button_next),
    .twelve_hour  (twelve_hour),
    .display_time (display_time),
    .pm           (pm),
    .alarm_ring   (alarm_ring),
    .timer_buzzer (timer_buzzer)
  );

  always #5 clk = ~clk;

  initial begin
    #(max_cycles * 10);
    $display("Timeout: run went past %0d clock cycles", max_cycles);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic next_cycle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // one-cycle button strobe, starting on a falling edge
  task automatic press(input logic t, input logic u, input logic n);
    button_tens  = t;
    button_units = u;
    button_next  = n;
    @(negedge clk);
    button_tens  = 1'b0;
    button_units = 1'b0;
    button_next  = 1'b0;
  endtask

  task automatic pulse_tick();
    tick = 1'b1;
    @(negedge clk);
    tick = 1'b0;
  endtask

  task automatic key_field(input int tens_n, input int units_n, input logic advance);
    repeat (tens_n) press(1'b1, 1'b0, 1'b0);
    repeat (units_n) press(1'b0, 1'b1, 1'b0);
    if (advance) begin
      press(1'b0, 1'b0, 1'b1);
    end
  endtask

  // leave run for a set mode, first set cycle clears the entry
  task automatic open_entry(input clock_mode_e m);
    mode = mode_run;
    next_cycle(1);
    mode = m;
    next_cycle(1);
  endtask

  task automatic load_value(input clock_mode_e m, input bcd_time_t v);
    open_entry(m);
    key_field(int'(v.hour[7:4]), int'(v.hour[3:0]), 1'b1);
    key_field(int'(v.min[7:4]), int'(v.min[3:0]), 1'b1);
    key_field(int'(v.sec[7:4]), int'(v.sec[3:0]), 1'b0);
    next_cycle(1);  // target register catches up with the entry
  endtask

  task automatic wait_ring(output int waited);
    waited = 0;
    while (!alarm_ring && waited < ring_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!alarm_ring) begin
      error_count++;
      test_errors++;
      $display("Timeout: alarm_ring stayed low for %0d cycles", ring_limit);
    end
  endtask

  task automatic check_time(input string what, input bcd_time_t got, input bcd_time_t exp);
    if (got !== exp) begin
      error_count++;
      test_errors++;
      $display("Error at %0t: %s expected %h:%h:%h, got %h:%h:%h", $time, what,
               exp.hour, exp.min, exp.sec, got.hour, got.min, got.sec);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      test_errors++;
      $display("Error at %0t: %s expected %b, got %b", $time, what, exp, got);
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d mismatches", test_count, name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic test_reset_state();
    check_time("time after reset", display_time, 24'h00_00_00);
    check_bit("ring after reset", alarm_ring, 1'b0);
    check_bit("buzzer after reset", timer_buzzer, 1'b0);
    end_test("reset state");
  endtask

  task automatic test_set_clock();
    int        th, uh, tm, um, ts, us;
    bcd_time_t exp;
    // counts may run one past the top digit to hit the wrap
    th = $urandom % 4;
    uh = $urandom % 12;
    tm = $urandom % 7;
    um = $urandom % 12;
    ts = $urandom % 7;
    us = $urandom % 12;
    exp.hour = {4'(th % (hour_tens_max + 1)), 4'(uh % (units_max + 1))};
    exp.min  = {4'(tm % (min_tens_max + 1)), 4'(um % (units_max + 1))};
    exp.sec  = {4'(ts % (sec_tens_max + 1)), 4'(us % (units_max + 1))};
    open_entry(mode_set_time);
    key_field(th, uh, 1'b1);
    key_field(tm, um, 1'b1);
    key_field(ts, us, 1'b0);
    next_cycle(1);
    check_time("keyed time", display_time, exp);
    end_test("set clock");
  endtask

  task automatic test_count_up();
    load_value(mode_set_time, 24'h23_59_58);
    pulse_tick();
    check_time("held in set mode", display_time, 24'h23_59_58);
    mode = mode_run;
    next_cycle(1);
    pulse_tick();
    check_time("first tick", display_time, 24'h23_59_59);
    pulse_tick();
    check_time("midnight rollover", display_time, 24'h00_00_00);
    end_test("count up");
  endtask

  task automatic test_twelve_hour();
    twelve_hour = 1'b1;
    load_value(mode_set_time, 24'h00_15_00);
    mode = mode_run;
    next_cycle(1);
    check_time("hour 00 in 12h", display_time, 24'h12_15_00);
    check_bit("pm at hour 00", pm, 1'b0);
    load_value(mode_set_time, 24'h12_15_00);
    mode = mode_run;
    next_cycle(1);
    check_time("hour 12 in 12h", display_time, 24'h12_15_00);
    check_bit("pm at hour 12", pm, 1'b1);
    load_value(mode_set_time, 24'h15_15_00);
    mode = mode_run;
    next_cycle(1);
    check_time("hour 15 in 12h", display_time, 24'h03_15_00);
    check_bit("pm at hour 15", pm, 1'b1);
    twelve_hour = 1'b0;  // back to 24h
    next_cycle(1);
    check_time("hour 15 in 24h", display_time, 24'h15_15_00);
    check_bit("pm in 24h", pm, 1'b0);
    end_test("12-hour format");
  endtask

  task automatic test_alarm();
    int waited;
    load_value(mode_set_alarm, 24'h07_30_45);
    check_time("alarm shown", display_time, 24'h07_30_00);  // keyed seconds dropped
    load_value(mode_set_time, 24'h07_29_59);
    mode = mode_run;
    next_cycle(1);
    check_bit("ring before tick", alarm_ring, 1'b0);
    pulse_tick();
    check_bit("ring in tick cycle", alarm_ring, 1'b0);
    wait_ring(waited);
    check_bit("ring one cycle later", waited == 1, 1'b1);
    end_test("alarm");
  endtask

  task automatic test_timer();
    load_value(mode_set_timer, 24'h00_01_01);
    check_time("timer shown", display_time, 24'h00_01_01);
    mode = mode_run;
    next_cycle(1);
    pulse_tick();
    check_time("timer after tick 1", clock_top_inst.timer_time, 24'h00_01_00);
    check_bit("buzzer after tick 1", timer_buzzer, 1'b0);
    pulse_tick();
    check_time("timer after tick 2", clock_top_inst.timer_time, 24'h00_00_59);
    check_bit("buzzer after tick 2", timer_buzzer, 1'b0);
    load_value(mode_set_timer, 24'h00_00_01);
    mode = mode_run;
    next_cycle(1);
    pulse_tick();
    check_time("timer at zero", clock_top_inst.timer_time, 24'h00_00_00);
    check_bit("buzzer at zero", timer_buzzer, 1'b0);
    pulse_tick();
    check_bit("buzzer latched", timer_buzzer, 1'b1);
    mode = mode_set_timer;  // reload
    next_cycle(1);
    check_bit("buzzer after reload", timer_buzzer, 1'b0);
    end_test("countdown timer");
  endtask

  initial begin
    void'($urandom(32'h4f57_503e));
    clk          = 1'b0;
    rst          = 1'b1;
    tick         = 1'b0;
    mode         = mode_run;
    button_tens  = 1'b0;
    button_units = 1'b0;
    button_next  = 1'b0;
    twelve_hour  = 1'b0;
    error_count  = 0;
    test_errors  = 0;
    test_count   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    next_cycle(1);

    test_reset_state();
    test_set_clock();
    test_count_up();
    test_twelve_hour();
    test_alarm();
    test_timer();

    $display("%0d tests run, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
clock_pkg.sv
time_setter.sv
time_counter.sv
countdown_timer.sv
alarm_matcher.sv
display_formatter.sv
clock_top.sv
tb_clock.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_clock
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
